//--- Makefile
# Verilator build and run of the motion core testbench

VERILATOR ?= verilator
TOP       ?= motion_core_tb
FILELIST  ?= motion_core.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal
SIM       := $(BUILD_DIR)/V$(TOP)
SRCS      := $(wildcard hw/*.sv test/*.sv)

.PHONY: all compile run clean

all: run

compile: $(SIM)

$(SIM): $(FILELIST) $(SRCS)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(SIM)
	@out="$$(./$(SIM))"; echo "$$out"; echo "$$out" | grep -qx "TEST PASS"

clean:
	rm -rf $(BUILD_DIR)

//--- hw/command_parser.sv
// Host word decoder; no back-pressure, so the host must check buffer_dtr before a move
`timescale 1ns/1ps
`default_nettype none

module command_parser (
  input  logic                                CLK,
  input  logic                                resetn,
  input  logic                                word_received,
  input  logic [motion_pkg::WORD_BITS-1:0]    word_data,
  output logic [motion_pkg::WORD_BITS-1:0]    word_reply,
  output logic [motion_pkg::NUM_MOTORS-1:0]   enable_mask,
  output logic [motion_pkg::DIVISOR_BITS-1:0] divisor,
  output logic                                buf_wr,
  output logic                                buf_commit,
  output logic [2:0]                          buf_index,
  output logic [motion_pkg::WORD_BITS-1:0]    buf_data,
  output logic [motion_pkg::NUM_MOTORS-1:0]   buf_dir
);
  import motion_pkg::*;

  logic                 word_received_q;
  logic                 word_edge;
  logic                 msg_open;     // Follow-on words expected
  opcode_e              opcode_q;
  opcode_e              header_op;
  logic [2:0]           word_count;   // Move data words taken so far
  logic [7:0]           cfg_addr;
  logic [WORD_BITS-1:0] status_read;
  logic [WORD_BITS-1:0] cfg_read;

  assign word_edge = word_received && !word_received_q;
  assign header_op = opcode_e'(word_data[WORD_BITS-1 -: 8]);

  always_comb begin
    case (word_data[7:0])
      STATUS_VERSION:      status_read = VERSION_WORD;
      // Motors, zero encoders, accumulator width
      STATUS_CHANNEL_INFO: status_read = WORD_BITS'({8'(DDA_BITS), 8'h00, 8'(NUM_MOTORS)});
      default:             status_read = '0;
    endcase
  end

  always_comb begin
    case (word_data[7:0])
      CONFIG_ENABLE:  cfg_read = WORD_BITS'(enable_mask);
      CONFIG_DIVISOR: cfg_read = WORD_BITS'(divisor);
      default:        cfg_read = '0;
    endcase
  end

  always_ff @(posedge CLK) begin
    if (!resetn) begin
      word_received_q <= 1'b0;
      word_reply      <= '0;
      msg_open        <= 1'b0;
      opcode_q        <= OP_STATUS;
      word_count      <= '0;
      cfg_addr        <= '0;
      enable_mask     <= '0;
      divisor         <= DEFAULT_DIVISOR;
      buf_wr          <= 1'b0;
      buf_commit      <= 1'b0;
      buf_dir         <= '0;
    end else begin
      word_received_q <= word_received;
      buf_wr          <= 1'b0;
      buf_commit      <= buf_wr && (buf_index == 3'(MOVE_WORDS));  // After the last data word
      if (word_edge) begin
        word_reply <= '0;  // Move data words and unknown headers reply zero
        if (!msg_open) begin
          opcode_q   <= header_op;
          word_count <= '0;
          case (header_op)
            OP_STATUS: word_reply <= status_read;
            OP_CONFIG: begin
              cfg_addr   <= word_data[7:0];
              word_reply <= cfg_read;
              msg_open   <= 1'b1;
            end
            OP_MOVE: begin
              buf_dir  <= word_data[NUM_MOTORS-1:0];
              msg_open <= 1'b1;
            end
            default: msg_open <= 1'b0;
          endcase
        end else if (opcode_q == OP_CONFIG) begin
          // Low 32 bits carry the value; undefined addresses are ignored
          if (cfg_addr == CONFIG_ENABLE) begin
            enable_mask <= word_data[NUM_MOTORS-1:0];
          end else if (cfg_addr == CONFIG_DIVISOR) begin
            divisor <= word_data[DIVISOR_BITS-1:0];
          end
          msg_open <= 1'b0;
        end else begin
          buf_wr    <= 1'b1;
          buf_index <= word_count + 3'd1;
          buf_data  <= word_data;
          if (word_count + 3'd1 == 3'(MOVE_WORDS)) begin
            msg_open   <= 1'b0;
            word_count <= '0;
          end else begin
            word_count <= word_count + 3'd1;
          end
        end
      end
    end
  end

  // Count wraps to zero when the last data word arrives
  a_word_count: assert property (@(posedge CLK) disable iff (!resetn)
    word_count < 3'(MOVE_WORDS))
    else $error("move word count ran past MOVE_WORDS");

endmodule

`default_nettype wire

//--- hw/dda_axis.sv
// One DDA axis; at most one step per tick, taken from the carry of the accumulator sum
`timescale 1ns/1ps
`default_nettype none

module dda_axis (
  input  logic                            CLK,
  input  logic                            resetn,
  input  logic                            dda_tick,
  input  logic                            load,
  input  logic                            running,
  input  logic [motion_pkg::DDA_BITS-1:0] increment,
  input  logic [motion_pkg::DDA_BITS-1:0] accel,
  output logic                            step
);
  import motion_pkg::*;

  logic [DDA_BITS-1:0] accum;
  logic [DDA_BITS-1:0] rate;  // Current increment
  logic [DDA_BITS:0]   sum;   // Carry in the top bit

  assign sum = {1'b0, accum} + {1'b0, rate};

  always_ff @(posedge CLK) begin
    if (load) begin
      accum <= '0;
      rate  <= increment;
    end else if (dda_tick && running) begin
      accum <= sum[DDA_BITS-1:0];
      rate  <= rate + accel;  // Second-order term
    end
  end

  always_ff @(posedge CLK) begin
    if (!resetn) begin
      step <= 1'b0;
    end else begin
      step <= dda_tick && running && !load && sum[DDA_BITS];
    end
  end

endmodule

`default_nettype wire

//--- hw/motion_core.sv
// Stepper command core top; host words arrive on a level strobe with no back-pressure
`timescale 1ns/1ps
`default_nettype none

module motion_core (
  input  logic                              CLK,
  input  logic                              resetn,
  input  logic                              word_received,
  input  logic [motion_pkg::WORD_BITS-1:0]  word_data,
  output logic [motion_pkg::WORD_BITS-1:0]  word_reply,
  output logic                              buffer_dtr,
  output logic                              move_done,
  output logic [motion_pkg::NUM_MOTORS-1:0] step,
  output logic [motion_pkg::NUM_MOTORS-1:0] dir,
  output logic [motion_pkg::NUM_MOTORS-1:0] enable
);
  import motion_pkg::*;

  logic [NUM_MOTORS-1:0]               enable_mask;
  logic [DIVISOR_BITS-1:0]             divisor;
  logic                                buf_wr;
  logic                                buf_commit;
  logic [2:0]                          buf_index;
  logic [WORD_BITS-1:0]                buf_data;
  logic [NUM_MOTORS-1:0]               buf_dir;
  logic                                slot_valid;
  logic [DURATION_BITS-1:0]            rd_duration;
  logic [NUM_MOTORS-1:0]               rd_dir;
  logic [NUM_MOTORS-1:0][DDA_BITS-1:0] rd_increment;
  logic [NUM_MOTORS-1:0][DDA_BITS-1:0] rd_accel;
  logic                                dda_tick;
  logic                                load;
  logic                                running;

  command_parser u_parser (
    .CLK           (CLK),
    .resetn        (resetn),
    .word_received (word_received),
    .word_data     (word_data),
    .word_reply    (word_reply),
    .enable_mask   (enable_mask),
    .divisor       (divisor),
    .buf_wr        (buf_wr),
    .buf_commit    (buf_commit),
    .buf_index     (buf_index),
    .buf_data      (buf_data),
    .buf_dir       (buf_dir)
  );

  move_buffer u_buffer (
    .CLK          (CLK),
    .resetn       (resetn),
    .buf_wr       (buf_wr),
    .buf_commit   (buf_commit),
    .move_done    (move_done),
    .buf_index    (buf_index),
    .buf_data     (buf_data),
    .buf_dir      (buf_dir),
    .slot_valid   (slot_valid),
    .buffer_dtr   (buffer_dtr),
    .rd_duration  (rd_duration),
    .rd_dir       (rd_dir),
    .rd_increment (rd_increment),
    .rd_accel     (rd_accel)
  );

  tick_divider u_divider (
    .CLK      (CLK),
    .resetn   (resetn),
    .divisor  (divisor),
    .dda_tick (dda_tick)
  );

  move_sequencer u_sequencer (
    .CLK         (CLK),
    .resetn      (resetn),
    .dda_tick    (dda_tick),
    .slot_valid  (slot_valid),
    .rd_duration (rd_duration),
    .load        (load),
    .running     (running),
    .move_done   (move_done)
  );

  for (genvar i = 0; i < NUM_MOTORS; i++) begin : g_axis
    dda_axis u_axis (
      .CLK       (CLK),
      .resetn    (resetn),
      .dda_tick  (dda_tick),
      .load      (load),
      .running   (running),
      .increment (rd_increment[i]),
      .accel     (rd_accel[i]),
      .step      (step[i])
    );
  end

  assign dir    = rd_dir;       // Direction of the slot being run
  assign enable = enable_mask;

endmodule

`default_nettype wire

//--- hw/motion_pkg.sv
// Shared motion constants; BUFFER_SIZE must stay a power of two that matches SLOT_BITS
`default_nettype none

package motion_pkg;

  localparam int NUM_MOTORS    = 2;
  localparam int WORD_BITS     = 64;
  localparam int DDA_BITS      = 64;
  localparam int DURATION_BITS = 32;
  localparam int BUFFER_SIZE   = 2;
  localparam int SLOT_BITS     = 1;
  localparam int MOVE_WORDS    = 1 + 2 * NUM_MOTORS;  // Duration plus two words per motor
  localparam int DIVISOR_BITS  = 8;

  localparam logic [DIVISOR_BITS-1:0] DEFAULT_DIVISOR = 8'd32;
  localparam logic [WORD_BITS-1:0]    VERSION_WORD    = 64'h0000_0000_0001_0000;

  // Status word addresses
  localparam logic [7:0] STATUS_VERSION      = 8'd0;
  localparam logic [7:0] STATUS_CHANNEL_INFO = 8'd1;

  // Config word addresses
  localparam logic [7:0] CONFIG_ENABLE  = 8'd0;
  localparam logic [7:0] CONFIG_DIVISOR = 8'd1;

  typedef enum logic [7:0] {
    OP_MOVE   = 8'h01,
    OP_STATUS = 8'hf1,
    OP_CONFIG = 8'hf2
  } opcode_e;

  typedef enum logic [1:0] {
    SEQ_IDLE,
    SEQ_LOAD,
    SEQ_RUN
  } seq_state_e;

endpackage

`default_nettype wire

//--- hw/move_buffer.sv
// Two-slot move store; slot count must be a power of two and a move sent into a full buffer overwrites the slot being run
`timescale 1ns/1ps
`default_nettype none

module move_buffer (
  input  logic                                                    CLK,
  input  logic                                                    resetn,
  input  logic                                                    buf_wr,
  input  logic                                                    buf_commit,
  input  logic                                                    move_done,
  input  logic [2:0]                                              buf_index,
  input  logic [motion_pkg::WORD_BITS-1:0]                        buf_data,
  input  logic [motion_pkg::NUM_MOTORS-1:0]                       buf_dir,
  output logic                                                    slot_valid,
  output logic                                                    buffer_dtr,
  output logic [motion_pkg::DURATION_BITS-1:0]                    rd_duration,
  output logic [motion_pkg::NUM_MOTORS-1:0]                       rd_dir,
  output logic [motion_pkg::NUM_MOTORS-1:0][motion_pkg::DDA_BITS-1:0] rd_increment,
  output logic [motion_pkg::NUM_MOTORS-1:0][motion_pkg::DDA_BITS-1:0] rd_accel
);
  import motion_pkg::*;

  logic [DURATION_BITS-1:0]               duration_mem [BUFFER_SIZE];
  logic [NUM_MOTORS-1:0]                  dir_mem      [BUFFER_SIZE];
  logic [NUM_MOTORS-1:0][DDA_BITS-1:0]    inc_mem      [BUFFER_SIZE];
  logic [NUM_MOTORS-1:0][DDA_BITS-1:0]    accel_mem    [BUFFER_SIZE];
  logic [SLOT_BITS-1:0]                   wr_ptr;
  logic [SLOT_BITS-1:0]                   rd_ptr;
  logic [SLOT_BITS:0]                     count;  // Occupied slots

  // Word 1 is the duration, then increment and increment-increment per motor
  always_ff @(posedge CLK) begin
    if (buf_wr) begin
      if (buf_index == 3'd1) begin
        duration_mem[wr_ptr] <= buf_data[DURATION_BITS-1:0];
      end
      for (int i = 0; i < NUM_MOTORS; i++) begin
        if (buf_index == 3'(2 + 2 * i)) inc_mem[wr_ptr][i] <= buf_data[DDA_BITS-1:0];
        if (buf_index == 3'(3 + 2 * i)) accel_mem[wr_ptr][i] <= buf_data[DDA_BITS-1:0];
      end
    end
    if (buf_commit) dir_mem[wr_ptr] <= buf_dir;
  end

  always_ff @(posedge CLK) begin
    if (!resetn) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (buf_commit) wr_ptr <= wr_ptr + 1'b1;
      if (move_done) rd_ptr <= rd_ptr + 1'b1;  // Retired slot is freed
      case ({buf_commit, move_done})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  assign slot_valid   = (count != '0);
  assign buffer_dtr   = (count < (SLOT_BITS+1)'(BUFFER_SIZE));
  assign rd_duration  = duration_mem[rd_ptr];
  assign rd_dir       = dir_mem[rd_ptr];
  assign rd_increment = inc_mem[rd_ptr];
  assign rd_accel     = accel_mem[rd_ptr];

  a_no_overfill: assert property (@(posedge CLK) disable iff (!resetn)
    buf_commit |-> count != (SLOT_BITS+1)'(BUFFER_SIZE))
    else $error("move committed while the buffer is full");

  // Sequencer must only retire a move that was buffered
  a_no_underflow: assert property (@(posedge CLK) disable iff (!resetn)
    move_done |-> count != '0)
    else $error("move_done with an empty buffer");

endmodule

`default_nettype wire

//--- hw/move_sequencer.sv
// Runs one buffered move per duration in ticks; a zero duration is not supported
`timescale 1ns/1ps
`default_nettype none

module move_sequencer (
  input  logic                                 CLK,
  input  logic                                 resetn,
  input  logic                                 dda_tick,
  input  logic                                 slot_valid,
  input  logic [motion_pkg::DURATION_BITS-1:0] rd_duration,
  output logic                                 load,
  output logic                                 running,
  output logic                                 move_done
);
  import motion_pkg::*;

  seq_state_e               state;
  logic [DURATION_BITS-1:0] tick_count;
  logic [DURATION_BITS-1:0] next_count;

  assign next_count = tick_count + 1'b1;
  assign load       = (state == SEQ_LOAD);
  assign running    = (state == SEQ_RUN);

  always_ff @(posedge CLK) begin
    if (!resetn) begin
      state      <= SEQ_IDLE;
      tick_count <= '0;
      move_done  <= 1'b0;
    end else begin
      move_done <= 1'b0;
      case (state)
        SEQ_IDLE: begin
          // Slot count still stale while the pop happens
          if (slot_valid && !move_done) state <= SEQ_LOAD;
        end
        SEQ_LOAD: begin
          tick_count <= '0;
          state      <= SEQ_RUN;
        end
        SEQ_RUN: begin
          if (dda_tick) begin
            tick_count <= next_count;
            if (next_count == rd_duration) begin
              move_done <= 1'b1;
              state     <= SEQ_IDLE;
            end
          end
        end
        default: state <= SEQ_IDLE;
      endcase
    end
  end

  a_nonzero_duration: assert property (@(posedge CLK) disable iff (!resetn)
    load |-> rd_duration != '0)
    else $error("loaded move has zero duration");

  a_load_run_exclusive: assert property (@(posedge CLK) disable iff (!resetn)
    !(load && running))
    else $error("load and running high together");

endmodule

`default_nettype wire

//--- hw/tick_divider.sv
// DDA tick every divisor cycles; a divisor of 0 acts as 1 and a new divisor restarts the count
`timescale 1ns/1ps
`default_nettype none

module tick_divider (
  input  logic                                 CLK,
  input  logic                                 resetn,
  input  logic [motion_pkg::DIVISOR_BITS-1:0]  divisor,
  output logic                                 dda_tick
);
  import motion_pkg::*;

  logic [DIVISOR_BITS-1:0] period;
  logic [DIVISOR_BITS-1:0] count;
  logic [DIVISOR_BITS-1:0] last_divisor;  // Detects a divisor change

  assign period = (divisor == '0) ? DIVISOR_BITS'(1) : divisor;

  always_ff @(posedge CLK) begin
    if (!resetn) begin
      count        <= '0;
      last_divisor <= '0;
      dda_tick     <= 1'b0;
    end else begin
      last_divisor <= divisor;
      if (divisor != last_divisor) begin
        count    <= period - 1'b1;  // Restart the full period
        dda_tick <= 1'b0;
      end else if (count == '0) begin
        count    <= period - 1'b1;
        dda_tick <= 1'b1;
      end else begin
        count    <= count - 1'b1;
        dda_tick <= 1'b0;
      end
    end
  end

endmodule

`default_nettype wire

//--- motion_core.f
hw/motion_pkg.sv
hw/tick_divider.sv
hw/command_parser.sv
hw/move_buffer.sv
hw/move_sequencer.sv
hw/dda_axis.sv
hw/motion_core.sv
test/motion_core_tb.sv

//--- test/motion_core_tb.sv
// Run from the project root so the vectors are found; the vector columns assume two motors
`timescale 1ns/1ps
`default_nettype none

module motion_core_tb;
  import motion_pkg::*;

  localparam int    MAX_VECTORS   = 32;
  localparam int    NUM_FIELDS    = 9;
  localparam int    RAND_DURATION = 40;
  localparam string VECTOR_FILE   = "test/motion_core_vectors.txt";

  logic                  CLK = 1'b0;
  logic                  resetn;
  logic                  word_received;
  logic [WORD_BITS-1:0]  word_data;
  logic [WORD_BITS-1:0]  word_reply;
  logic                  buffer_dtr;
  logic                  move_done;
  logic [NUM_MOTORS-1:0] step;
  logic [NUM_MOTORS-1:0] dir;
  logic [NUM_MOTORS-1:0] enable;

  logic [8*10-1:0]       kinds  [MAX_VECTORS];
  logic [63:0]           fields [MAX_VECTORS][NUM_FIELDS];
  int                    num_vectors;
  int                    errors;
  int                    tests;
  int                    moves_sent;
  int                    moves_checked;
  int                    limit_cycles;
  logic                  limit_ready = 1'b0;
  integer                seed;

  int                    run_steps [NUM_MOTORS];
  int                    done_steps_q [$];  // Motor by motor per retired move
  logic [NUM_MOTORS-1:0] done_dir_q [$];
  int                    exp_steps_q [$];
  logic [NUM_MOTORS-1:0] exp_dir_q [$];

  motion_core u_dut (
    .CLK           (CLK),
    .resetn        (resetn),
    .word_received (word_received),
    .word_data     (word_data),
    .word_reply    (word_reply),
    .buffer_dtr    (buffer_dtr),
    .move_done     (move_done),
    .step          (step),
    .dir           (dir),
    .enable        (enable)
  );

  always #10 CLK = ~CLK;

  // Step and retirement monitor sampled mid-cycle
  always @(negedge CLK) begin
    if (resetn) begin
      for (int m = 0; m < NUM_MOTORS; m++) begin
        if (step[m]) run_steps[m]++;
      end
      if (move_done) begin
        for (int m = 0; m < NUM_MOTORS; m++) begin
          done_steps_q.push_back(run_steps[m]);
          run_steps[m] = 0;
        end
        done_dir_q.push_back(dir);  // Direction of the move just retired
      end
    end
  end

  initial begin
    wait (limit_ready);
    repeat (limit_cycles) @(posedge CLK);
    $display("Timeout: run did not finish within %0d cycles", limit_cycles);
    $display("TEST FAIL");
    $finish;
  end

  task automatic check_word(input string name, input logic [WORD_BITS-1:0] got,
                            input logic [WORD_BITS-1:0] exp);
    if (got !== exp) begin
      $display("ERROR at %0t ns: %s is %h, expected %h", $time, name, got, exp);
      errors++;
    end
  endtask

  task automatic check_mask(input string name, input logic [NUM_MOTORS-1:0] got,
                            input logic [NUM_MOTORS-1:0] exp);
    if (got !== exp) begin
      $display("ERROR at %0t ns: %s is %b, expected %b", $time, name, got, exp);
      errors++;
    end
  endtask

  task automatic check_count(input string name, input int got, input int exp);
    if (got != exp) begin
      $display("ERROR at %0t ns: %s is %0d, expected %0d", $time, name, got, exp);
      errors++;
    end
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("ERROR at %0t ns: %s is %b, expected %b", $time, name, got, exp);
      errors++;
    end
  endtask

  // Carry count of one axis over a whole move using 65-bit sums
  function automatic int model_steps(input logic [DURATION_BITS-1:0] duration,
                                     input logic [DDA_BITS-1:0] increment,
                                     input logic [DDA_BITS-1:0] accel);
    logic [DDA_BITS-1:0] acc;
    logic [DDA_BITS-1:0] rate;
    logic [DDA_BITS:0]   total;
    int                  carries;
    acc     = '0;
    rate    = increment;
    carries = 0;
    for (int t = 0; t < int'(duration); t++) begin
      total = {1'b0, acc} + {1'b0, rate};
      if (total[DDA_BITS]) carries++;
      acc  = total[DDA_BITS-1:0];
      rate = rate + accel;
    end
    return carries;
  endfunction

  // Starts and ends two ns after a rising edge
  task automatic send_word(input logic [WORD_BITS-1:0] data,
                           output logic [WORD_BITS-1:0] reply);
    word_data     = data;
    word_received = 1'b1;
    repeat (2) @(posedge CLK);
    #2;
    word_received = 1'b0;
    repeat (4) @(posedge CLK);
    #2;
    reply = word_reply;
  endtask

  task automatic wait_done(input int count);
    do begin
      @(posedge CLK);
    end while (done_dir_q.size() < count);
    #2;
  endtask

  task automatic retire_moves();
    int err_before;
    while (moves_checked < moves_sent) begin
      wait_done(moves_checked + 1);
      err_before = errors;
      check_flag("buffer_dtr", buffer_dtr, 1'b1);  // A slot was just freed
      check_mask("dir", done_dir_q[moves_checked], exp_dir_q[moves_checked]);
      for (int m = 0; m < NUM_MOTORS; m++) begin
        check_count($sformatf("step[%0d] count", m),
                    done_steps_q[NUM_MOTORS * moves_checked + m],
                    exp_steps_q[NUM_MOTORS * moves_checked + m]);
      end
      tests++;
      $display("Move %0d retired: %s", moves_checked, (errors == err_before) ? "ok" : "FAILED");
      moves_checked++;
    end
  endtask

  task automatic send_move(input logic [WORD_BITS-1:0] words [1+MOVE_WORDS],
                           input int expected [NUM_MOTORS], input bit back_to_back);
    logic [WORD_BITS-1:0] reply;
    for (int k = 0; k <= MOVE_WORDS; k++) begin
      send_word(words[k], reply);
      check_word("word_reply", reply, '0);  // Move words carry no telemetry
    end
    exp_dir_q.push_back(words[0][NUM_MOTORS-1:0]);
    for (int m = 0; m < NUM_MOTORS; m++) begin
      exp_steps_q.push_back(expected[m]);
    end
    moves_sent++;
    check_flag("buffer_dtr", buffer_dtr, (moves_sent - done_dir_q.size()) < BUFFER_SIZE);
    if (!back_to_back) retire_moves();
  endtask

  task automatic run_vector(input int i);
    logic [WORD_BITS-1:0] reply;
    logic [WORD_BITS-1:0] words [1+MOVE_WORDS];
    int                   expected [NUM_MOTORS];
    int                   err_before;
    string                name;
    err_before = errors;
    name       = "";
    if (kinds[i] == "STATUS" || kinds[i] == "BAD") begin
      name = (kinds[i] == "BAD") ? "unknown opcode" : "status read";
      send_word(fields[i][0], reply);
      check_word("word_reply", reply, fields[i][6]);
    end else if (kinds[i] == "CONFIG_W") begin
      name = "config write";
      send_word(fields[i][0], reply);
      send_word(fields[i][1], reply);
      check_mask("enable", enable, fields[i][6][NUM_MOTORS-1:0]);
    end else if (kinds[i] == "CONFIG_R") begin
      name = "config read";
      send_word(fields[i][0], reply);
      check_word("word_reply", reply, fields[i][6]);
      send_word(fields[i][1], reply);  // Rewrites the same value to close the message
    end else if (kinds[i] == "MOVE") begin
      for (int k = 0; k <= MOVE_WORDS; k++) begin
        words[k] = fields[i][k];
      end
      for (int m = 0; m < NUM_MOTORS; m++) begin
        expected[m] = model_steps(fields[i][1][DURATION_BITS-1:0], fields[i][2 + 2 * m],
                                  fields[i][3 + 2 * m]);
        if (expected[m] != int'(fields[i][6 + m])) begin
          $display("Vector %0d: step count of motor %0d disagrees with the step model", i, m);
          errors++;
        end
      end
      send_move(words, expected, fields[i][8][0]);
    end else begin
      $display("Vector %0d has an unknown message kind", i);
      errors++;
    end
    if (kinds[i] != "MOVE") begin
      tests++;
      $display("Test %0d %s: %s", i, name, (errors == err_before) ? "ok" : "FAILED");
    end
  endtask

  task automatic load_vectors(output bit loaded);
    int              fd;
    int              n;
    string           line;
    logic [8*10-1:0] kind;
    logic [63:0]     f [NUM_FIELDS];
    loaded      = 1'b0;
    num_vectors = 0;
    fd          = $fopen(VECTOR_FILE, "r");
    if (fd != 0) begin
      loaded = 1'b1;
      while (!$feof(fd)) begin
        line = "";
        n    = $fgets(line, fd);
        if (line.len() > 1 && line[0] != "#") begin
          n = $sscanf(line, "%s %h %h %h %h %h %h %h %h %h", kind, f[0], f[1], f[2], f[3],
                      f[4], f[5], f[6], f[7], f[8]);
          if (n == 1 + NUM_FIELDS && num_vectors < MAX_VECTORS) begin
            kinds[num_vectors] = kind;
            for (int k = 0; k < NUM_FIELDS; k++) begin
              fields[num_vectors][k] = f[k];
            end
            num_vectors++;
          end else begin
            $display("Malformed vector line: %s", line);
            loaded = 1'b0;
          end
        end
      end
      $fclose(fd);
    end
    if (num_vectors == 0) loaded = 1'b0;
  endtask

  // Moves dominate the run time, so scale by their summed durations
  task automatic set_limit();
    int dur_sum;
    int max_div;
    dur_sum = RAND_DURATION;
    max_div = int'(DEFAULT_DIVISOR);
    for (int i = 0; i < num_vectors; i++) begin
      if (kinds[i] == "MOVE") dur_sum += int'(fields[i][1][DURATION_BITS-1:0]);
      if ((kinds[i] == "CONFIG_W" || kinds[i] == "CONFIG_R") &&
          fields[i][0][7:0] == CONFIG_DIVISOR && int'(fields[i][1][7:0]) > max_div) begin
        max_div = int'(fields[i][1][7:0]);
      end
    end
    limit_cycles = dur_sum * max_div * 4 + 2000;
    limit_ready  = 1'b1;
  endtask

  task automatic verify_reset();
    int err_before;
    err_before = errors;
    check_word("word_reply", word_reply, '0);
    check_flag("buffer_dtr", buffer_dtr, 1'b1);
    check_flag("move_done", move_done, 1'b0);
    check_mask("step", step, '0);
    check_mask("enable", enable, '0);
    tests++;
    $display("Reset state: %s", (errors == err_before) ? "ok" : "FAILED");
  endtask

  task automatic run_random_move();
    logic [WORD_BITS-1:0] words [1+MOVE_WORDS];
    int                   expected [NUM_MOTORS];
    logic [31:0]          rnd_hi;
    logic [31:0]          rnd_lo;
    rnd_lo   = $random(seed);
    words[0] = '0;
    words[0][WORD_BITS-1 -: 8] = OP_MOVE;
    words[0][NUM_MOTORS-1:0]   = rnd_lo[NUM_MOTORS-1:0];
    words[1] = WORD_BITS'(RAND_DURATION);
    for (int m = 0; m < NUM_MOTORS; m++) begin
      rnd_hi = $random(seed);
      rnd_lo = $random(seed);
      words[2 + 2 * m] = {rnd_hi, rnd_lo};
      rnd_lo = $random(seed);
      words[3 + 2 * m] = {32'h0, rnd_lo};  // Small second-order term
      expected[m] = model_steps(RAND_DURATION, words[2 + 2 * m], words[3 + 2 * m]);
    end
    send_move(words, expected, 1'b0);
  endtask

  initial begin
    bit loaded;
    int err_before;
    resetn        = 1'b0;
    word_received = 1'b0;
    word_data     = '0;
    seed          = 32'h06836e99;
    errors        = 0;
    tests         = 0;
    moves_sent    = 0;
    moves_checked = 0;
    load_vectors(loaded);
    if (!loaded) begin
      $display("Could not read the vectors from %s", VECTOR_FILE);
      $display("TEST FAIL");
      $finish;
    end else begin
      set_limit();
      repeat (10) @(posedge CLK);
      #2;
      resetn = 1'b1;
      @(posedge CLK);
      #2;
      verify_reset();
      for (int i = 0; i < num_vectors; i++) begin
        run_vector(i);
      end
      run_random_move();
      repeat (20) @(posedge CLK);
      err_before = errors;
      check_count("move_done pulses", done_dir_q.size(), moves_sent);
      tests++;
      $display("Move count: %s", (errors == err_before) ? "ok" : "FAILED");
      $display("Summary: %0d tests, %0d errors", tests, errors);
      if (errors == 0) begin
        $display("TEST PASS");
      end else begin
        $display("TEST FAIL");
      end
      $finish;
    end
  end

endmodule

`default_nettype wire

//--- test/motion_core_vectors.txt
# kind header d1 d2 d3 d4 d5 exp_a exp_b exp_c, all hex
# STATUS/BAD/CONFIG_R exp_a=reply, CONFIG_W exp_a=enable, MOVE exp_a/b=steps exp_c=1 back-to-back
STATUS f100000000000000 0 0 0 0 0 10000 0 0
STATUS f100000000000007 0 0 0 0 0 0 0 0
STATUS f100000000000001 0 0 0 0 0 400002 0 0
BAD 7700000000000000 0 0 0 0 0 0 0 0
STATUS f100000000000000 0 0 0 0 0 10000 0 0
CONFIG_W f200000000000000 3 0 0 0 0 3 0 0
CONFIG_R f200000000000000 3 0 0 0 0 3 0 0
CONFIG_W f200000000000001 4 0 0 0 0 3 0 0
CONFIG_R f200000000000001 4 0 0 0 0 4 0 0
MOVE 0100000000000002 10 4000000000000000 0 2000000000000000 0200000000000000 4 2 0
MOVE 0100000000000001 18 8000000000000000 0 0 0100000000000000 c 1 1
MOVE 0100000000000003 c c000000000000000 0 1000000000000000 0 9 0 0
STATUS f100000000000001 0 0 0 0 0 400002 0 0
